// File: rtl/issue_pkg.sv
`default_nettype none

package issue_pkg;

   // ************************************************************************
   // Datapath sizes
   // ************************************************************************
   localparam int data_w       = 32;
   localparam int tag_w        = 6;
   localparam int queue_depth  = 4;
   localparam int ptr_w        = $clog2(queue_depth);
   localparam int cnt_w        = $clog2(queue_depth + 1);
   localparam int mult_latency = 3;    // Start edge to result edge.

   // ************************************************************************
   // Opcodes
   // ************************************************************************
   typedef enum logic [3:0] {
      OP_ADD = 4'h0,
      OP_SUB = 4'h1,
      OP_AND = 4'h2,
      OP_OR  = 4'h3,
      OP_XOR = 4'h4,
      OP_SLT = 4'h5,     // Signed compare.
      OP_MUL = 4'h6
   } op_e;

endpackage

`default_nettype wire

// File: rtl/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

   localparam int apb_addr_w = 4;
   localparam int apb_data_w = 32;

   // Register map.
   localparam logic [apb_addr_w-1:0] reg_rs     = 4'h0;
   localparam logic [apb_addr_w-1:0] reg_rt     = 4'h4;
   localparam logic [apb_addr_w-1:0] reg_cmd    = 4'h8;
   localparam logic [apb_addr_w-1:0] reg_status = 4'hC;

   // Command word fields.
   localparam int cmd_op_lsb  = 0;
   localparam int cmd_tag_lsb = 8;

endpackage

`default_nettype wire

// File: rtl/issue_if.sv
`timescale 1ns/100ps
`default_nettype none

// Instruction handshake between dispatch, queue and issue unit.
interface issue_if import issue_pkg::*; ();
   logic              valid;
   logic              ready;
   op_e               opcode;
   logic [data_w-1:0] rs;
   logic [data_w-1:0] rt;
   logic [tag_w-1:0]  tag;

   modport producer (output valid, opcode, rs, rt, tag, input ready);
   modport consumer (input valid, opcode, rs, rt, tag, output ready);
endinterface

interface exec_if import issue_pkg::*; ();
   logic              start;   // No ready here.
   op_e               opcode;
   logic [data_w-1:0] rs;
   logic [data_w-1:0] rt;
   logic [tag_w-1:0]  tag;

   modport issuer (output start, opcode, rs, rt, tag);
   modport unit   (input start, opcode, rs, rt, tag);
endinterface

interface cdb_if import issue_pkg::*; ();
   logic              valid;
   logic [data_w-1:0] data;
   logic [tag_w-1:0]  tag;
   logic              carry;
   logic              overflow;

   modport source (output valid, data, tag, carry, overflow);
   modport sink   (input valid, data, tag, carry, overflow);
endinterface

`default_nettype wire

// File: rtl/exec_int.sv
`timescale 1ns/100ps
`default_nettype none

module exec_int import issue_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   exec_if.unit   req,
   cdb_if.source  res
);
   logic [data_w:0]   sum;
   logic [data_w:0]   diff;
   logic              slt;
   logic [data_w-1:0] result;
   logic              carry;
   logic              overflow;

   assign sum  = {1'b0, req.rs} + {1'b0, req.rt};
   assign diff = {1'b0, req.rs} + {1'b0, ~req.rt} + 1'b1;  // Carry out is not borrow.
   assign slt  = $signed(req.rs) < $signed(req.rt);

   always_comb begin
      result   = '0;
      carry    = 1'b0;
      overflow = 1'b0;
      case (req.opcode)
         OP_ADD: begin
            result   = sum[data_w-1:0];
            carry    = sum[data_w];
            overflow = (req.rs[data_w-1] == req.rt[data_w-1]) &
                       (sum[data_w-1] != req.rs[data_w-1]);
         end
         OP_SUB: begin
            result   = diff[data_w-1:0];
            carry    = diff[data_w];
            overflow = (req.rs[data_w-1] != req.rt[data_w-1]) &
                       (diff[data_w-1] != req.rs[data_w-1]);
         end
         OP_AND:  result = req.rs & req.rt;
         OP_OR:   result = req.rs | req.rt;
         OP_XOR:  result = req.rs ^ req.rt;
         OP_SLT:  result = {{(data_w-1){1'b0}}, slt};
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) res.valid <= 1'b0;
      else         res.valid <= req.start;
   end

   always_ff @(posedge clk) begin
      if (req.start) begin
         res.data     <= result;
         res.tag      <= req.tag;
         res.carry    <= carry;
         res.overflow <= overflow;
      end
   end

endmodule

`default_nettype wire

// File: rtl/exec_mult.sv
`timescale 1ns/100ps
`default_nettype none

module exec_mult import issue_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   exec_if.unit   req,
   cdb_if.source  res
);
   logic [data_w-1:0]       a_q;
   logic [data_w-1:0]       b_q;
   logic [data_w-1:0]       p_ll;         // Low halves product.
   logic [data_w/2-1:0]     p_x;          // Cross terms, low half only.
   logic [data_w-1:0]       prod_q;
   logic [mult_latency-1:0] vld;
   logic [tag_w-1:0]        tag_q [mult_latency];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) vld <= '0;
      else         vld <= {vld[mult_latency-2:0], req.start};
   end

   always_ff @(posedge clk) begin
      tag_q[0] <= req.tag;
      for (int i = 1; i < mult_latency; i++)
         tag_q[i] <= tag_q[i-1];
   end

   always_ff @(posedge clk) begin
      a_q    <= req.rs;                                              // Stage 1.
      b_q    <= req.rt;
      p_ll   <= a_q[data_w/2-1:0] * b_q[data_w/2-1:0];               // Stage 2.
      p_x    <= a_q[data_w/2-1:0] * b_q[data_w-1:data_w/2] +
                a_q[data_w-1:data_w/2] * b_q[data_w/2-1:0];
      prod_q <= p_ll + {p_x, {(data_w/2){1'b0}}};                   // Stage 3.
   end

   assign res.valid    = vld[mult_latency-1];
   assign res.data     = prod_q;
   assign res.tag      = tag_q[mult_latency-1];
   assign res.carry    = 1'b0;
   assign res.overflow = 1'b0;

endmodule

`default_nettype wire

// File: rtl/issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit import issue_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   issue_if.consumer         in,
   output logic              cdb_valid,
   output logic [data_w-1:0] cdb_data,
   output logic [tag_w-1:0]  cdb_tag,
   output logic              cdb_carry,
   output logic              cdb_overflow
);
   logic                    head_mul;
   logic                    pop;
   logic [mult_latency-2:0] mult_due;

   exec_if int_req ();
   exec_if mul_req ();
   cdb_if  int_res ();
   cdb_if  mul_res ();

   // ************************************************************************
   // Issue and CDB slot reservation
   // ************************************************************************
   assign head_mul = (in.opcode == OP_MUL);

   // Top bit set means a multiply lands in the slot an ALU op would take.
   assign in.ready = head_mul | ~mult_due[mult_latency-2];
   assign pop      = in.valid & in.ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         mult_due <= '0;
      else
         mult_due <= (mult_due << 1) | (mult_latency-1)'(pop & head_mul);
   end

   assign int_req.start  = pop & ~head_mul;
   assign int_req.opcode = in.opcode;
   assign int_req.rs     = in.rs;
   assign int_req.rt     = in.rt;
   assign int_req.tag    = in.tag;

   assign mul_req.start  = pop & head_mul;
   assign mul_req.opcode = in.opcode;
   assign mul_req.rs     = in.rs;
   assign mul_req.rt     = in.rt;
   assign mul_req.tag    = in.tag;

   exec_int exec_int_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (int_req.unit),
      .res    (int_res.source)
   );

   exec_mult exec_mult_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mul_req.unit),
      .res    (mul_res.source)
   );

   // ************************************************************************
   // CDB select
   // ************************************************************************
   assign cdb_valid = int_res.valid | mul_res.valid;

   always_comb begin
      if (mul_res.valid) begin
         cdb_data     = mul_res.data;
         cdb_tag      = mul_res.tag;
         cdb_carry    = mul_res.carry;
         cdb_overflow = mul_res.overflow;
      end else begin
         cdb_data     = int_res.data;
         cdb_tag      = int_res.tag;
         cdb_carry    = int_res.carry;
         cdb_overflow = int_res.overflow;
      end
   end

endmodule

`default_nettype wire

// File: rtl/issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module issue_queue import issue_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   issue_if.consumer        in,
   issue_if.producer        out,
   output logic [cnt_w-1:0] count
);
   logic              push;
   logic              pop;
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   op_e               op_mem  [queue_depth];
   logic [data_w-1:0] rs_mem  [queue_depth];
   logic [data_w-1:0] rt_mem  [queue_depth];
   logic [tag_w-1:0]  tag_mem [queue_depth];

   assign push = in.valid & in.ready;
   assign pop  = out.valid & out.ready;

   assign in.ready  = (count != cnt_w'(queue_depth));
   assign out.valid = (count != '0);      // Head is never the entry written this cycle.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         op_mem[wr_ptr]  <= in.opcode;
         rs_mem[wr_ptr]  <= in.rs;
         rt_mem[wr_ptr]  <= in.rt;
         tag_mem[wr_ptr] <= in.tag;
      end
   end

   assign out.opcode = op_mem[rd_ptr];
   assign out.rs     = rs_mem[rd_ptr];
   assign out.rt     = rt_mem[rd_ptr];
   assign out.tag    = tag_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/apb_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module apb_dispatch import issue_pkg::*, apb_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr,
   issue_if.producer             q,
   input  logic [cnt_w-1:0]      count
);
   logic              access;
   logic              addr_ok;
   logic              op_ok;
   logic              cmd_wr;
   logic [data_w-1:0] rs_q;
   logic [data_w-1:0] rt_q;

   assign access = psel & penable;
   assign addr_ok = (paddr == reg_rs) | (paddr == reg_rt) |
                    (paddr == reg_cmd) | (paddr == reg_status);
   assign cmd_wr = access & pwrite & (paddr == reg_cmd);

   always_comb begin
      case (pwdata[cmd_op_lsb +: 4])
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL: op_ok = 1'b1;
         default: op_ok = 1'b0;
      endcase
   end

   // ************************************************************************
   // Operand registers
   // ************************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rs_q <= '0;
         rt_q <= '0;
      end else if (access && pwrite) begin
         if (paddr == reg_rs) rs_q <= pwdata;
         if (paddr == reg_rt) rt_q <= pwdata;
      end
   end

   // Push happens at the edge that completes the command write.
   assign q.valid  = cmd_wr & op_ok;
   assign q.opcode = op_e'(pwdata[cmd_op_lsb +: 4]);
   assign q.tag    = pwdata[cmd_tag_lsb +: tag_w];
   assign q.rs     = rs_q;
   assign q.rt     = rt_q;

   assign pready  = ~(cmd_wr & op_ok & ~q.ready);     // Stall while full.
   assign pslverr = access & (~addr_ok | (pwrite & (paddr == reg_status)) |
                              (cmd_wr & ~op_ok));

   always_comb begin
      case (paddr)
         reg_rs:     prdata = rs_q;
         reg_rt:     prdata = rt_q;
         reg_status: prdata = {{(apb_data_w - cnt_w){1'b0}}, count};
         default:    prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module issue_top import issue_pkg::*, apb_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  cdb_valid,
   output logic [data_w-1:0]     cdb_data,
   output logic [tag_w-1:0]      cdb_tag,
   output logic                  cdb_carry,
   output logic                  cdb_overflow
);
   logic [cnt_w-1:0] count;

   issue_if disp_q ();     // Dispatch to queue.
   issue_if q_iu ();       // Queue to issue unit.

   apb_dispatch apb_dispatch_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .q       (disp_q.producer),
      .count   (count)
   );

   issue_queue issue_queue_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .in     (disp_q.consumer),
      .out    (q_iu.producer),
      .count  (count)
   );

   issue_unit issue_unit_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .in           (q_iu.consumer),
      .cdb_valid    (cdb_valid),
      .cdb_data     (cdb_data),
      .cdb_tag      (cdb_tag),
      .cdb_carry    (cdb_carry),
      .cdb_overflow (cdb_overflow)
   );

endmodule

`default_nettype wire

// File: tests/tb_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_issue_top import issue_pkg::*, apb_regs_pkg::*; ();

   localparam int n_alu       = 16;
   localparam int n_mix       = 24;
   localparam int n_burst     = 8;
   localparam int n_tags      = 2**tag_w;
   localparam int total_apb   = 1 + 3*n_alu + 3*n_mix + (4 + n_burst) + 4;
   localparam int cycle_limit = 20*total_apb + 200;

   logic                  clk;
   logic                  arst_n;
   logic [apb_addr_w-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_data_w-1:0] pwdata;
   logic [apb_data_w-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  cdb_valid;
   logic [data_w-1:0]     cdb_data;
   logic [tag_w-1:0]      cdb_tag;
   logic                  cdb_carry;
   logic                  cdb_overflow;

   integer            seed        = 77;
   int                errors      = 0;
   int                beats       = 0;
   int                cycles      = 0;
   int                outstanding = 0;
   logic              pending   [n_tags];
   logic [data_w-1:0] exp_data  [n_tags];
   logic              exp_carry [n_tags];
   logic              exp_ovf   [n_tags];

   issue_top issue_top_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .cdb_valid    (cdb_valid),
      .cdb_data     (cdb_data),
      .cdb_tag      (cdb_tag),
      .cdb_carry    (cdb_carry),
      .cdb_overflow (cdb_overflow)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("ERROR: run stopped after %0d cycles without finishing the tests", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   // ************************************************************************
   // Reference model and scoreboard
   // ************************************************************************
   task automatic ref_model(input op_e op, input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                            output logic [data_w-1:0] r, output logic c, output logic v);
      longint      s;
      logic [63:0] p;
      r = '0;
      c = 1'b0;
      v = 1'b0;
      case (op)
         OP_ADD: begin
            r = a + b;
            c = (64'(a) + 64'(b)) > 64'hffff_ffff;
            s = longint'($signed(a)) + longint'($signed(b));
            v = (s != longint'(int'(s)));      // Sum does not fit in 32 signed bits.
         end
         OP_SUB: begin
            r = a - b;
            c = (a >= b);                      // No borrow.
            s = longint'($signed(a)) - longint'($signed(b));
            v = (s != longint'(int'(s)));
         end
         OP_AND: r = a & b;
         OP_OR:  r = a | b;
         OP_XOR: r = a ^ b;
         OP_SLT: r = {31'b0, $signed(a) < $signed(b)};
         OP_MUL: begin
            p = 64'(a) * 64'(b);
            r = p[31:0];
         end
         default: r = '0;
      endcase
   endtask

   task automatic expect_result(input op_e op, input logic [data_w-1:0] a,
                                input logic [data_w-1:0] b, input logic [tag_w-1:0] tag);
      logic [data_w-1:0] r;
      logic              c;
      logic              v;
      ref_model(op, a, b, r, c, v);
      exp_data[tag]  = r;
      exp_carry[tag] = c;
      exp_ovf[tag]   = v;
      pending[tag]   = 1'b1;
      outstanding    = outstanding + 1;
   endtask

   // CDB outputs are registered, so the falling edge sees a settled beat.
   always @(negedge clk) begin
      if (arst_n && cdb_valid) begin
         beats = beats + 1;
         if (!pending[cdb_tag]) begin
            $display("ERROR: CDB result for tag %0d with no instruction outstanding", cdb_tag);
            errors = errors + 1;
         end else begin
            if (cdb_data !== exp_data[cdb_tag]) begin
               $display("FAIL cdb_data tag %h: got %h, expected %h",
                        cdb_tag, cdb_data, exp_data[cdb_tag]);
               errors = errors + 1;
            end
            if (cdb_carry !== exp_carry[cdb_tag]) begin
               $display("FAIL cdb_carry tag %h: got %h, expected %h",
                        cdb_tag, cdb_carry, exp_carry[cdb_tag]);
               errors = errors + 1;
            end
            if (cdb_overflow !== exp_ovf[cdb_tag]) begin
               $display("FAIL cdb_overflow tag %h: got %h, expected %h",
                        cdb_tag, cdb_overflow, exp_ovf[cdb_tag]);
               errors = errors + 1;
            end
            pending[cdb_tag] = 1'b0;
            outstanding      = outstanding - 1;
         end
      end
   end

   // ************************************************************************
   // APB host
   // ************************************************************************
   // Runs from one falling edge to another, so transfers follow back to back.
   task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                           input logic [apb_data_w-1:0] wdata,
                           output logic [apb_data_w-1:0] rdata, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      while (!pready) begin                    // Queue full.
         @(negedge clk);
         #1;
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [apb_addr_w-1:0] addr,
                            input logic [apb_data_w-1:0] data, input logic exp_err);
      logic [apb_data_w-1:0] rd;
      logic                  err;
      apb_xfer(1'b1, addr, data, rd, err);
      if (err !== exp_err) begin
         $display("FAIL pslverr write %h: got %h, expected %h", addr, err, exp_err);
         errors = errors + 1;
      end
   endtask

   task automatic apb_read(input logic [apb_addr_w-1:0] addr,
                           output logic [apb_data_w-1:0] data, input logic exp_err);
      logic err;
      apb_xfer(1'b0, addr, '0, data, err);
      if (err !== exp_err) begin
         $display("FAIL pslverr read %h: got %h, expected %h", addr, err, exp_err);
         errors = errors + 1;
      end
   endtask

   function automatic logic [31:0] cmd_word(input logic [3:0] op, input logic [tag_w-1:0] tag);
      return {18'b0, tag, 4'b0, op};
   endfunction

   task automatic pick_operand(output logic [data_w-1:0] v);
      case ({$random(seed)} % 8)
         0:       v = 32'h7fff_ffff;
         1:       v = 32'h8000_0000;
         2:       v = 32'hffff_ffff;
         default: v = $random(seed);
      endcase
   endtask

   task automatic send_instr(input op_e op, input logic [tag_w-1:0] tag);
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      pick_operand(a);
      pick_operand(b);
      apb_write(reg_rs, a, 1'b0);
      apb_write(reg_rt, b, 1'b0);
      expect_result(op, a, b, tag);
      apb_write(reg_cmd, cmd_word(op, tag), 1'b0);
   endtask

   // Waits for the CDB to go quiet, then names every tag still missing.
   task automatic drain();
      int n;
      n = 0;
      while (outstanding != 0 && n < 40) begin
         @(negedge clk);
         #1;
         n++;
      end
      for (int t = 0; t < n_tags; t++) begin
         if (pending[t]) begin
            $display("ERROR: tag %0d never returned on the CDB", t);
            errors     = errors + 1;
            pending[t] = 1'b0;
         end
      end
      outstanding = 0;
      @(negedge clk);
   endtask

   task automatic finish_test(input int num, input string name, input int err_start);
      if (errors == err_start)
         $display("test %0d %s: pass", num, name);
      else
         $display("test %0d %s: %0d errors", num, name, errors - err_start);
   endtask

   // ************************************************************************
   // Test sequence
   // ************************************************************************
   initial begin
      int                    start;
      int                    n0;
      int                    r;
      logic [apb_data_w-1:0] rd;
      logic [data_w-1:0]     a;
      logic [data_w-1:0]     b;
      op_e                   op;
      for (int t = 0; t < n_tags; t++)
         pending[t] = 1'b0;
      arst_n  = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      start = errors;
      @(negedge clk);
      if (cdb_valid !== 1'b0) begin
         $display("FAIL cdb_valid: got %h, expected %h", cdb_valid, 1'b0);
         errors = errors + 1;
      end
      if (pready !== 1'b1) begin
         $display("FAIL pready: got %h, expected %h", pready, 1'b1);
         errors = errors + 1;
      end
      apb_read(reg_status, rd, 1'b0);
      if (rd !== 32'd0) begin
         $display("FAIL reg_status: got %h, expected %h", rd, 32'd0);
         errors = errors + 1;
      end
      finish_test(5, "reset", start);

      start = errors;
      n0    = beats;
      for (int i = 0; i < n_alu; i++)
         send_instr(op_e'(4'({$random(seed)} % 6)), tag_w'(i));
      drain();
      if (beats - n0 != n_alu) begin
         $display("ERROR: expected %0d CDB results, saw %0d", n_alu, beats - n0);
         errors = errors + 1;
      end
      finish_test(1, "random alu", start);

      start = errors;
      n0    = beats;
      for (int i = 0; i < n_mix; i++) begin
         r  = {$random(seed)} % 10;
         op = (r >= 6) ? OP_MUL : op_e'(4'(r));
         send_instr(op, tag_w'(i));
      end
      drain();
      if (beats - n0 != n_mix) begin
         $display("ERROR: expected %0d CDB results, saw %0d", n_mix, beats - n0);
         errors = errors + 1;
      end
      finish_test(2, "alu and mul mix", start);

      // Back to back commands on fixed operands, alternating units.
      start = errors;
      pick_operand(a);
      pick_operand(b);
      apb_write(reg_rs, a, 1'b0);
      apb_write(reg_rt, b, 1'b0);
      for (int i = 0; i < n_burst; i++) begin
         op = (i % 2 == 0) ? OP_MUL : OP_SUB;
         expect_result(op, a, b, tag_w'(i));
         apb_write(reg_cmd, cmd_word(op, tag_w'(i)), 1'b0);
      end
      // The last SUB still waits out the CDB slot of the multiply ahead of it.
      apb_read(reg_status, rd, 1'b0);
      if (rd !== 32'd1) begin
         $display("FAIL reg_status: got %h, expected %h", rd, 32'd1);
         errors = errors + 1;
      end
      drain();
      apb_read(reg_status, rd, 1'b0);
      if (rd !== 32'd0) begin
         $display("FAIL reg_status: got %h, expected %h", rd, 32'd0);
         errors = errors + 1;
      end
      finish_test(3, "command burst", start);

      start = errors;
      n0    = beats;
      apb_write(reg_cmd, cmd_word(4'hb, 6'h3f), 1'b1);
      apb_write(4'h2, 32'h1234_5678, 1'b1);
      apb_read(4'h5, rd, 1'b1);
      apb_write(reg_status, 32'h7, 1'b1);
      repeat (2*mult_latency + 4) @(negedge clk);
      if (beats != n0) begin
         $display("ERROR: a rejected access produced %0d CDB results", beats - n0);
         errors = errors + 1;
      end
      finish_test(4, "error responses", start);

      $display("%0d CDB results checked, %0d errors", beats, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
rtl/issue_pkg.sv
rtl/apb_regs_pkg.sv
rtl/issue_if.sv
rtl/exec_int.sv
rtl/exec_mult.sv
rtl/issue_unit.sv
rtl/issue_queue.sv
rtl/apb_dispatch.sv
rtl/issue_top.sv
tests/tb_issue_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds tb_issue_top with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_issue_top \
   -f verilog.f -o sim_issue_top > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_issue_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Done: no errors" sim.log; then
   exit 0
fi
exit 1
